/* common/ioctl_pkg.sv */
// Download protocol definitions shared by the router and the loaders
// Word, byte address and index widths
// Index codes for cartridge, CD data and cheat downloads
// Data word union with raw and CD header views

`default_nettype none

package ioctl_pkg;

	localparam int IOCTL_WORD_W  = 16;
	localparam int IOCTL_ADDR_W  = 25;
	localparam int IOCTL_INDEX_W = 8;

	// Low six index bits, bit 0 of a cartridge index picks SuperGrafx
	localparam logic [5:0] IDX_CART_MAX = 6'h01;
	localparam logic [5:0] IDX_CD_DATA  = 6'h02;

	// Cheat codes use the full index
	localparam logic [IOCTL_INDEX_W-1:0] IDX_CHEAT = '1;

	// First word of a CD data download
	typedef struct packed {
		logic        dm;
		logic [14:0] len;
	} cd_header_t;

	typedef union packed {
		logic [IOCTL_WORD_W-1:0] raw;
		cd_header_t              hdr;
	} ioctl_word_t;

endpackage

`default_nettype wire

/* common/cart_pkg.sv */
// Cartridge and cheat definitions
// ROM write address width
// Populous signature blocks, words and bank select bit
// Cheat record layout

`default_nettype none

package cart_pkg;

	localparam int ROM_ADDR_W = 24;

	// 16-byte blocks that carry the signature, one per bank
	localparam logic [ROM_ADDR_W-1:0] SIG_BLOCK_A = 24'h002120;
	localparam logic [ROM_ADDR_W-1:0] SIG_BLOCK_B = 24'h001F20;

	// Expected words at block offsets 6, 8, 10 and 12
	localparam logic [3:0][15:0] SIG_WORDS = {16'h5355, 16'h4F4C, 16'h5550, 16'h4F50};

	// Picks which populous flag a block clears
	localparam int ROM_BANK_BIT = 13;

	localparam int CHEAT_FIELD_W = 32;

	// Fields arrive big endian, the consumer rearranges them
	typedef struct packed {
		logic [CHEAT_FIELD_W-1:0] flags;
		logic [CHEAT_FIELD_W-1:0] address;
		logic [CHEAT_FIELD_W-1:0] compare;
		logic [CHEAT_FIELD_W-1:0] replace;
	} cheat_code_t;

endpackage

`default_nettype wire

/* common/dl_if.sv */
// Download stream from the router to one loader
// Active, start pulse, word strobe, byte address and data word

`timescale 1ns/1ps
`default_nettype none

interface dl_if;
	import ioctl_pkg::*;

	logic                    active;
	logic                    start;
	logic                    wr;
	logic [IOCTL_ADDR_W-1:0] addr;
	ioctl_word_t             word;

	modport router (output active, start, wr, addr, word);
	modport loader (input active, start, wr, addr, word);

endinterface

`default_nettype wire

/* hdl/download_router.sv */
// Download router
// Index decode into ROM, cheat and CD data targets
// Registered word stream with per-target active, start and strobe

`timescale 1ns/1ps
`default_nettype none

module download_router (
	input  wire logic                                 clk_sys,
	input  wire logic                                 reset,
	input  wire logic                                 ioctl_download,
	input  wire logic [ioctl_pkg::IOCTL_INDEX_W-1:0]  ioctl_index,
	input  wire logic                                 ioctl_wr,
	input  wire logic [ioctl_pkg::IOCTL_ADDR_W-1:0]   ioctl_addr,
	input  wire logic [ioctl_pkg::IOCTL_WORD_W-1:0]   ioctl_dout,
	dl_if.router                                      rom_dl,
	dl_if.router                                      cheat_dl,
	dl_if.router                                      cd_dl
);
	import ioctl_pkg::*;

	// Target order is {cd, cheat, rom}
	logic [2:0]              sel;
	logic [2:0]              act_q;
	logic [2:0]              start_q;
	logic [2:0]              wr_q;
	logic [IOCTL_ADDR_W-1:0] addr_q;
	ioctl_word_t             word_q;

	assign sel[0] = ioctl_download && (ioctl_index[5:0] <= IDX_CART_MAX);
	assign sel[1] = ioctl_download && (ioctl_index == IDX_CHEAT);
	assign sel[2] = ioctl_download && (ioctl_index[5:0] == IDX_CD_DATA);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			act_q   <= '0;
			start_q <= '0;
			wr_q    <= '0;
		end else begin
			act_q   <= sel;
			start_q <= sel & ~act_q;
			wr_q    <= sel & {3{ioctl_wr}};
		end
	end

	// Payload follows the host every cycle
	always_ff @(posedge clk_sys) begin
		addr_q     <= ioctl_addr;
		word_q.raw <= ioctl_dout;
	end

	assign rom_dl.active   = act_q[0];
	assign rom_dl.start    = start_q[0];
	assign rom_dl.wr       = wr_q[0];
	assign rom_dl.addr     = addr_q;
	assign rom_dl.word     = word_q;

	assign cheat_dl.active = act_q[1];
	assign cheat_dl.start  = start_q[1];
	assign cheat_dl.wr     = wr_q[1];
	assign cheat_dl.addr   = addr_q;
	assign cheat_dl.word   = word_q;

	assign cd_dl.active    = act_q[2];
	assign cd_dl.start     = start_q[2];
	assign cd_dl.wr        = wr_q[2];
	assign cd_dl.addr      = addr_q;
	assign cd_dl.word      = word_q;

endmodule

`default_nettype wire

/* rom_loader/rom_loader.sv */
// ROM loader
// Toggle request/acknowledge writes with host back-pressure
// Optional 16-bit bit reversal of each word
// SuperGrafx latch and Populous signature check per bank

`timescale 1ns/1ps
`default_nettype none

module rom_loader (
	input  wire logic                                 clk_sys,
	input  wire logic                                 reset,
	input  wire logic                                 rom_swap,
	input  wire logic                                 mem_wr_ack,
	dl_if.loader                                      dl,
	input  wire logic                                 sgx_sel,
	output logic                                      ioctl_wait,
	output logic                                      mem_wr_req,
	output logic [cart_pkg::ROM_ADDR_W-1:0]           mem_wr_addr,
	output logic [ioctl_pkg::IOCTL_WORD_W-1:0]        mem_wr_data,
	output logic                                      sgx,
	output logic [1:0]                                populous
);
	import ioctl_pkg::*;
	import cart_pkg::*;

	logic [IOCTL_WORD_W-1:0] rom_word;
	logic                    in_sig_block;
	logic                    sig_slot;
	logic [1:0]              sig_idx;

	// Bit 0 trades places with bit 15 and so on
	always_comb begin
		rom_word = dl.word.raw;
		if (rom_swap) begin
			for (int i = 0; i < IOCTL_WORD_W; i++) begin
				rom_word[i] = dl.word.raw[IOCTL_WORD_W-1-i];
			end
		end
	end

	////////////////////////////////////////////////////////////////////
	// Signature lookup on the current write address
	////////////////////////////////////////////////////////////////////

	assign in_sig_block = (mem_wr_addr[ROM_ADDR_W-1:4] == SIG_BLOCK_A[ROM_ADDR_W-1:4]) ||
	                      (mem_wr_addr[ROM_ADDR_W-1:4] == SIG_BLOCK_B[ROM_ADDR_W-1:4]);
	// Offsets 6..12 map to word slots 0..3
	assign sig_idx  = mem_wr_addr[2:1] - 2'd3;
	assign sig_slot = (mem_wr_addr[3:1] >= 3'd3) && (mem_wr_addr[3:1] <= 3'd6);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ioctl_wait  <= 1'b0;
			mem_wr_req  <= 1'b0;
			mem_wr_addr <= '0;
			populous    <= 2'b11;
			sgx         <= 1'b0;
		end else if (dl.start) begin
			mem_wr_addr <= '0;
			populous    <= 2'b11;
			sgx         <= sgx_sel;
		end else if (dl.wr && dl.active) begin
			ioctl_wait  <= 1'b1;
			mem_wr_req  <= ~mem_wr_req;
			if (in_sig_block && sig_slot && (rom_word != SIG_WORDS[sig_idx])) begin
				populous[mem_wr_addr[ROM_BANK_BIT]] <= 1'b0;
			end
		end else if (ioctl_wait && (mem_wr_req == mem_wr_ack)) begin
			// Write done, release the host
			ioctl_wait  <= 1'b0;
			mem_wr_addr <= mem_wr_addr + 2'd2;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (dl.wr) begin
			mem_wr_data <= rom_word;
		end
	end

	// Host must hold off while a write is outstanding
	a_no_wr_while_wait: assert property (@(posedge clk_sys) disable iff (reset)
		dl.wr |-> !ioctl_wait);

	a_req_when_idle: assert property (@(posedge clk_sys) disable iff (reset)
		$changed(mem_wr_req) |-> !$past(ioctl_wait));

endmodule

`default_nettype wire

/* hdl/cheat_loader.sv */
// Cheat loader
// Collects eight words into one cheat record and strobes it out

`timescale 1ns/1ps
`default_nettype none

module cheat_loader (
	input  wire logic            clk_sys,
	input  wire logic            reset,
	dl_if.loader                 dl,
	output cart_pkg::cheat_code_t cheat_code,
	output logic                 cheat_valid
);
	import cart_pkg::*;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheat_valid <= 1'b0;
		end else begin
			cheat_valid <= dl.wr && dl.active && (dl.addr[3:0] == 4'd14);
		end
	end

	// Bottom word first within each field
	always_ff @(posedge clk_sys) begin
		if (dl.wr && dl.active) begin
			case (dl.addr[3:0])
				4'd0:  cheat_code.flags[15:0]    <= dl.word.raw;
				4'd2:  cheat_code.flags[31:16]   <= dl.word.raw;
				4'd4:  cheat_code.address[15:0]  <= dl.word.raw;
				4'd6:  cheat_code.address[31:16] <= dl.word.raw;
				4'd8:  cheat_code.compare[15:0]  <= dl.word.raw;
				4'd10: cheat_code.compare[31:16] <= dl.word.raw;
				4'd12: cheat_code.replace[15:0]  <= dl.word.raw;
				4'd14: cheat_code.replace[31:16] <= dl.word.raw;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/cd_data_loader.sv */
// CD data loader
// Header parse for data mode and byte length
// Word to byte serialiser, low byte first, with byte count limit

`timescale 1ns/1ps
`default_nettype none

module cd_data_loader (
	input  wire logic  clk_sys,
	input  wire logic  reset,
	dl_if.loader       dl,
	output logic [7:0] cd_data,
	output logic       cd_wr,
	output logic       cd_dm
);
	import ioctl_pkg::*;

	logic                    hdr_seen;
	logic [14:0]             dat_len;
	logic [14:0]             dat_cnt;
	logic                    dat_busy;
	logic                    byte_hi;
	logic [IOCTL_WORD_W-1:0] dat_q;

	always_ff @(posedge clk_sys) begin
		if (reset || dl.start) begin
			hdr_seen <= 1'b0;
			dat_len  <= '0;
			dat_cnt  <= '0;
		end else if (dl.wr && dl.active) begin
			if (!hdr_seen) begin
				cd_dm    <= dl.word.hdr.dm;
				dat_len  <= dl.word.hdr.len;
				dat_cnt  <= '0;
				hdr_seen <= 1'b1;
			end else if (dat_cnt < dat_len) begin
				dat_busy <= 1'b1;
				byte_hi  <= 1'b0;
				dat_q    <= dl.word.raw;
			end
		end

		// Each byte takes two cycles, strobe then gap
		if (dat_busy) begin
			if (!cd_wr) begin
				cd_wr <= 1'b1;
			end else begin
				cd_wr   <= 1'b0;
				byte_hi <= ~byte_hi;
				dat_cnt <= dat_cnt + 15'd1;
				if (byte_hi || (dat_cnt >= dat_len - 15'd1)) begin
					dat_busy <= 1'b0;
				end
			end
		end

		if (reset) begin
			cd_wr    <= 1'b0;
			dat_busy <= 1'b0;
			cd_dm    <= 1'b0;
		end
	end

	assign cd_data = byte_hi ? dat_q[15:8] : dat_q[7:0];

	// A data word must wait until the previous one is fully sent
	a_word_spacing: assert property (@(posedge clk_sys) disable iff (reset)
		(dl.wr && dl.active && hdr_seen) |-> !dat_busy);

endmodule

`default_nettype wire

/* hdl/pce_loader_top.sv */
// Download side of the console core
// Host download port, ROM memory handshake, cheat and CD data outputs
// Router plus ROM, cheat and CD data loaders

`timescale 1ns/1ps
`default_nettype none

module pce_loader_top (
	input  wire logic                                 clk_sys,
	input  wire logic                                 reset,

	// Host download port
	input  wire logic                                 ioctl_download,
	input  wire logic [ioctl_pkg::IOCTL_INDEX_W-1:0]  ioctl_index,
	input  wire logic                                 ioctl_wr,
	input  wire logic [ioctl_pkg::IOCTL_ADDR_W-1:0]   ioctl_addr,
	input  wire logic [ioctl_pkg::IOCTL_WORD_W-1:0]   ioctl_dout,
	output wire logic                                 ioctl_wait,

	input  wire logic                                 rom_swap,

	// ROM memory write handshake
	output wire logic                                 mem_wr_req,
	input  wire logic                                 mem_wr_ack,
	output wire logic [cart_pkg::ROM_ADDR_W-1:0]      mem_wr_addr,
	output wire logic [ioctl_pkg::IOCTL_WORD_W-1:0]   mem_wr_data,

	output wire logic                                 sgx,
	output wire logic [1:0]                           populous,

	output cart_pkg::cheat_code_t                     cheat_code,
	output wire logic                                 cheat_valid,

	output wire logic [7:0]                           cd_data,
	output wire logic                                 cd_wr,
	output wire logic                                 cd_dm
);

	dl_if rom_dl ();
	dl_if cheat_dl ();
	dl_if cd_dl ();

	download_router u_router (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.rom_dl         (rom_dl),
		.cheat_dl       (cheat_dl),
		.cd_dl          (cd_dl)
	);

	rom_loader u_rom (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.rom_swap    (rom_swap),
		.mem_wr_ack  (mem_wr_ack),
		.dl          (rom_dl),
		.sgx_sel     (ioctl_index[0]),
		.ioctl_wait  (ioctl_wait),
		.mem_wr_req  (mem_wr_req),
		.mem_wr_addr (mem_wr_addr),
		.mem_wr_data (mem_wr_data),
		.sgx         (sgx),
		.populous    (populous)
	);

	cheat_loader u_cheat (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl          (cheat_dl),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid)
	);

	cd_data_loader u_cd (
		.clk_sys (clk_sys),
		.reset   (reset),
		.dl      (cd_dl),
		.cd_data (cd_data),
		.cd_wr   (cd_wr),
		.cd_dm   (cd_dm)
	);

endmodule

`default_nettype wire

/* tests/tb_pce_loader.sv */
// Testbench for the download side of the console core
// Host model with download, word strobe and wait handling
// Memory model answering toggle requests after a random delay
// Monitors for cheat and CD strobes, pattern file driven checks, watchdog

`timescale 1ns/1ps
`default_nettype none

module tb_pce_loader;
	import ioctl_pkg::*;
	import cart_pkg::*;

	localparam int NUM_RECORDS  = 63;
	localparam int RESET_CYCLES = 8;

	logic                     clk_sys = 1'b0;
	logic                     reset;
	logic                     ioctl_download;
	logic [IOCTL_INDEX_W-1:0] ioctl_index;
	logic                     ioctl_wr;
	logic [IOCTL_ADDR_W-1:0]  ioctl_addr;
	logic [IOCTL_WORD_W-1:0]  ioctl_dout;
	logic                     ioctl_wait;
	logic                     rom_swap;
	logic                     mem_wr_req;
	logic                     mem_wr_ack;
	logic [ROM_ADDR_W-1:0]    mem_wr_addr;
	logic [IOCTL_WORD_W-1:0]  mem_wr_data;
	logic                     sgx;
	logic [1:0]               populous;
	cheat_code_t              cheat_code;
	logic                     cheat_valid;
	logic [7:0]               cd_data;
	logic                     cd_wr;
	logic                     cd_dm;

	logic [31:0]              pat [0:NUM_RECORDS*5-1];
	logic [7:0]               cd_bytes [$];
	integer                   seed = 51839;
	int                       ack_delay;
	int                       mem_count;
	int                       cheat_count;
	int                       cd_count;
	int                       watchdog_cycles = 0;
	logic [ROM_ADDR_W-1:0]    last_addr;
	logic [IOCTL_WORD_W-1:0]  last_data;
	logic [ROM_ADDR_W-1:0]    rom_next;

	pce_loader_top u_dut (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wait     (ioctl_wait),
		.rom_swap       (rom_swap),
		.mem_wr_req     (mem_wr_req),
		.mem_wr_ack     (mem_wr_ack),
		.mem_wr_addr    (mem_wr_addr),
		.mem_wr_data    (mem_wr_data),
		.sgx            (sgx),
		.populous       (populous),
		.cheat_code     (cheat_code),
		.cheat_valid    (cheat_valid),
		.cd_data        (cd_data),
		.cd_wr          (cd_wr),
		.cd_dm          (cd_dm)
	);

	always #4 clk_sys = ~clk_sys;

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Result: FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] got,
			input logic [31:0] expected);
		$display("mismatch at %0t: %s is %h, expected %h", $time, what, got, expected);
		$display("Result: FAILED");
		$fatal(1, "run stopped");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Memory model and strobe monitors
	//////////////////////////////////////////////////////////////////////

	// Acknowledge toggles 1 to 6 cycles after a new request
	always @(negedge clk_sys) begin
		if (reset) begin
			ack_delay = 0;
		end else begin
			// An outstanding write keeps the host waiting
			assert (mem_wr_req == mem_wr_ack || ioctl_wait == 1'b1)
				else report_mismatch("ioctl_wait during a write", ioctl_wait, 1);
			if (ack_delay != 0) begin
				ack_delay = ack_delay - 1;
				if (ack_delay == 0) begin
					mem_wr_ack = ~mem_wr_ack;
				end
			end else if (mem_wr_req != mem_wr_ack) begin
				last_addr = mem_wr_addr;
				last_data = mem_wr_data;
				mem_count = mem_count + 1;
				ack_delay = 1 + ($unsigned($random(seed)) % 6);
			end
		end
	end

	always @(negedge clk_sys) begin
		if (!reset && cheat_valid) begin
			cheat_count = cheat_count + 1;
		end
		if (!reset && cd_wr) begin
			cd_bytes.push_back(cd_data);
			cd_count = cd_count + 1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Host side
	//////////////////////////////////////////////////////////////////////

	// Mixes every address bit into the filler word
	function automatic logic [15:0] fill_pattern(input logic [23:0] addr);
		return addr[15:0] ^ {addr[7:0], addr[23:16]} ^ 16'h5a3c;
	endfunction

	function automatic logic [31:0] probe_signal(input logic [31:0] sel);
		case (sel)
			0: return populous;
			1: return sgx;
			2: return cd_dm;
			3: return cheat_count;
			4: return cd_count;
			default: return mem_count;
		endcase
	endfunction

	function automatic logic [31:0] cheat_field(input logic [31:0] sel);
		case (sel)
			0: return cheat_code.flags;
			1: return cheat_code.address;
			2: return cheat_code.compare;
			default: return cheat_code.replace;
		endcase
	endfunction

	// Drop the previous download so the router sees a new start
	task automatic begin_download(input logic [7:0] index, input logic swap);
		ioctl_download = 1'b0;
		repeat (2) @(negedge clk_sys);
		ioctl_index    = index;
		rom_swap       = swap;
		ioctl_download = 1'b1;
		repeat (3) @(negedge clk_sys);
		mem_count   = 0;
		cheat_count = 0;
		cd_count    = 0;
		rom_next    = '0;
		cd_bytes.delete();
	endtask

	task automatic pulse_host_word(input logic [23:0] addr, input logic [15:0] word);
		ioctl_addr = {1'b0, addr};
		ioctl_dout = word;
		ioctl_wr   = 1'b1;
		@(negedge clk_sys);
		ioctl_wr   = 1'b0;
	endtask

	task automatic write_rom_word(input logic [23:0] addr, input logic [15:0] word,
			input logic [15:0] expected);
		int count_before;
		count_before = mem_count;
		pulse_host_word(addr, word);
		while (!ioctl_wait) @(negedge clk_sys);
		while (ioctl_wait) @(negedge clk_sys);
		assert (mem_count == count_before + 1)
			else report_mismatch("memory writes", mem_count, count_before + 1);
		assert (last_addr == addr) else report_mismatch("mem_wr_addr", last_addr, addr);
		assert (last_data == expected) else report_mismatch("mem_wr_data", last_data, expected);
		rom_next = addr + 24'd2;
	endtask

	// Filler runs with swap off
	task automatic fill_rom(input logic [23:0] end_addr);
		while (rom_next < end_addr) begin
			write_rom_word(rom_next, fill_pattern(rom_next), fill_pattern(rom_next));
		end
	endtask

	// Cheat and CD streams have no back-pressure, CD needs five idle cycles
	task automatic send_side_word(input logic [23:0] addr, input logic [15:0] word);
		pulse_host_word(addr, word);
		repeat (8) @(negedge clk_sys);
	endtask

	task automatic check_cd_byte(input logic [7:0] expected);
		logic [7:0] got;
		if (cd_bytes.size() == 0) begin
			abort_run("a CD byte was expected but none was written");
		end else begin
			got = cd_bytes.pop_front();
			assert (got == expected) else report_mismatch("cd_data", got, expected);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Pattern sequencer and watchdog
	//////////////////////////////////////////////////////////////////////

	initial begin
		int          rec;
		int          fill_words;
		logic [31:0] kind;
		logic [31:0] addr;
		logic [31:0] word;
		logic [31:0] expected;

		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		rom_swap       = 1'b0;
		mem_wr_ack     = 1'b0;
		mem_count      = 0;
		cheat_count    = 0;
		cd_count       = 0;
		rom_next       = '0;
		$readmemh("tests/pce_loader_patterns.txt", pat);

		// Every filler word counts as one record
		fill_words = 0;
		for (int i = 0; i < NUM_RECORDS; i++) begin
			if (pat[i*5] == 32'd3) begin
				fill_words = fill_words + pat[i*5+2] / 2;
			end
		end
		watchdog_cycles = 40 * (NUM_RECORDS + fill_words) + RESET_CYCLES;

		repeat (RESET_CYCLES) @(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);

		rec = 0;
		while (rec < NUM_RECORDS && pat[rec*5] !== 32'd0) begin
			kind     = pat[rec*5];
			addr     = pat[rec*5+2];
			word     = pat[rec*5+3];
			expected = pat[rec*5+4];
			case (kind)
				1: begin_download(pat[rec*5+1][7:0], word[0]);
				2: write_rom_word(addr[23:0], word[15:0], expected[15:0]);
				3: fill_rom(addr[23:0]);
				4: send_side_word(addr[23:0], word[15:0]);
				5: assert (probe_signal(addr) == expected)
					else report_mismatch("signal check", probe_signal(addr), expected);
				6: assert (cheat_field(addr) == expected)
					else report_mismatch("cheat field", cheat_field(addr), expected);
				7: check_cd_byte(expected[7:0]);
				default: abort_run("the pattern file holds an unknown record type");
			endcase
			rec = rec + 1;
		end

		ioctl_download = 1'b0;
		repeat (4) @(negedge clk_sys);
		if (rec > 0 && rec < NUM_RECORDS && pat[rec*5] === 32'd0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			abort_run("the pattern file ends without an end record");
		end
	end

	initial begin
		wait (watchdog_cycles != 0);
		repeat (watchdog_cycles) @(posedge clk_sys);
		abort_run("timeout, the run did not finish in time");
	end

endmodule

`default_nettype wire

/* tests/pce_loader_patterns.txt */
// Columns in hex: type index address word expected, check types 5 select by address
// 1 start(word=swap) 2 rom 3 fill 4 side word 5 signal 6 cheat field 7 cd byte 0 end
1 01 000000 0000 0000
2 01 000000 1234 1234
2 01 000002 abcd abcd
2 01 000004 0f0f 0f0f
5 01 000001 0000 0001
5 01 000005 0000 0003
1 00 000000 0001 0000
2 00 000000 0001 8000
2 00 000002 1234 2c48
2 00 000004 c3a5 a5c3
5 00 000001 0000 0000
1 00 000000 0000 0000
3 00 001f26 0000 0000
2 00 001f26 4f50 4f50
2 00 001f28 5550 5550
2 00 001f2a 4f4c 4f4c
2 00 001f2c 5355 5355
3 00 002126 0000 0000
2 00 002126 4f50 4f50
2 00 002128 5550 5550
2 00 00212a 4f4c 4f4c
2 00 00212c 5355 5355
5 00 000000 0000 0003
5 00 000004 0000 0000
1 00 000000 0000 0000
3 00 001f26 0000 0000
2 00 001f26 1234 1234
5 00 000000 0000 0002
3 00 002126 0000 0000
2 00 002126 4f50 4f50
2 00 002128 5550 5550
2 00 00212a 0000 0000
5 00 000000 0000 0000
1 00 000000 0000 0000
5 00 000000 0000 0003
1 ff 000000 0000 0000
4 ff 000000 1111 0000
4 ff 000002 2222 0000
4 ff 000004 3333 0000
4 ff 000006 4444 0000
4 ff 000008 5555 0000
4 ff 00000a 6666 0000
4 ff 00000c 7777 0000
4 ff 00000e 8888 0000
5 ff 000003 0000 0001
6 ff 000000 0000 22221111
6 ff 000001 0000 44443333
6 ff 000002 0000 66665555
6 ff 000003 0000 88887777
1 02 000000 0000 0000
4 02 000000 8005 0000
4 02 000002 3412 0000
4 02 000004 7856 0000
4 02 000006 bc9a 0000
5 02 000004 0000 0005
5 02 000002 0000 0001
5 02 000005 0000 0000
7 02 000000 0000 0012
7 02 000000 0000 0034
7 02 000000 0000 0056
7 02 000000 0000 0078
7 02 000000 0000 009a
0 00 000000 0000 0000

/* sources.f */
common/ioctl_pkg.sv
common/cart_pkg.sv
common/dl_if.sv
hdl/download_router.sv
rom_loader/rom_loader.sv
hdl/cheat_loader.sv
hdl/cd_data_loader.sv
hdl/pce_loader_top.sv
tests/tb_pce_loader.sv

/* Bender.yml */
package:
  name: pce_loader

sources:
  - files:
      - common/ioctl_pkg.sv
      - common/cart_pkg.sv
      - common/dl_if.sv
      - hdl/download_router.sv
      - rom_loader/rom_loader.sv
      - hdl/cheat_loader.sv
      - hdl/cd_data_loader.sv
      - hdl/pce_loader_top.sv
  - target: test
    files:
      - tests/tb_pce_loader.sv
